//--- testbench/cpu_stim.txt
// tag_addr_data: 1 instruction at pc, 2 data preload, 3 expected store in order, 4 halt pc
// Base registers, ALU chain with saturation and stores
1_0000_AA00 1_0002_BA01 1_0004_AB00 1_0006_BB02 1_0008_A1F0 1_000A_B17F 1_000C_A220 1_000E_0312
1_0010_93B0 1_0012_A400 1_0014_B480 1_0016_1542 1_0018_95B1 1_001A_2635 1_001C_4764 1_001E_5873
1_0020_6914 1_0022_6C84 1_0024_97B2 1_0026_98B3 1_0028_99B4 1_002A_9CB5 1_002C_96B6
// Load-use stall and store forwarding
1_002E_81A0 1_0030_0211 1_0032_92B7 1_0034_83A1 1_0036_93B8
// Conditional branches, skipped stores at 3C 46 4E 56 5A 60 64
1_0038_1433 1_003A_C201 1_003C_93B0 1_003E_C001 1_0040_94B1 1_0042_0522 1_0044_C401 1_0046_95B0
1_0048_C601 1_004A_95B2 1_004C_C801 1_004E_93B0 1_0050_CA01 1_0052_1641 1_0054_C601 1_0056_93B0
1_0058_CA01 1_005A_93B0 1_005C_0755 1_005E_CC01 1_0060_93B0 1_0062_CE01 1_0064_93B0 1_0066_97B3
1_0068_C201 1_006A_96B4
// PCS and BR, skipped stores at 74 80 82
1_006C_E800 1_006E_AD08 1_0070_098D 1_0072_DE90 1_0074_99B0 1_0076_99B5 1_0078_98B6 1_007A_AE84
1_007C_D2E0 1_007E_D0E0 1_0080_93B0 1_0082_93B0
// Writes to r0, then halt
1_0084_0011 1_0086_A055 1_0088_90B7 1_008A_F000
2_0100_1234 2_0102_0011
3_0200_7FFF 3_0202_8000 3_0204_FFF0 3_0206_FFFE 3_0208_07FF 3_020A_EFFF 3_020C_FFFF 3_020E_2468
3_01F0_0011 3_0202_0000 3_0204_48D0 3_0206_7FFF 3_0208_EDCC 3_020A_0076 3_020C_006E 3_020E_0000
4_008A_0000

//--- tb.f
+incdir+hw
hw/cpu_pkg.sv
hw/register_file.sv
hw/alu.sv
hw/fetch_unit.sv
hw/pipeline_control.sv
hw/execute_unit.sv
hw/memory_stage.sv
hw/cpu_top.sv
testbench/cpu_assert.sv
testbench/tb_cpu.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cpu -f tb.f -Mdir obj_dir -o tb_cpu \
  && ./obj_dir/tb_cpu \
  || exit 1

//--- testbench/tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 16;
  localparam int DRIVE_DELAY = 10;
  localparam string STIM_FILE = "testbench/cpu_stim.txt";

  logic  clk = 1'b0;
  logic  reset;
  word_t inst;
  word_t mem_rdata;
  word_t pc;
  word_t mem_addr;
  word_t mem_wdata;
  logic  mem_ren;
  logic  mem_wen;
  logic  hlt;

  // Stimulus lines are tag, address, data
  logic [35:0] stim [256];
  word_t       imem [256];
  word_t       dmem [1024];
  word_t       exp_addr [$];
  word_t       exp_data [$];
  word_t       halt_pc;
  int          prog_words;
  int          store_idx;

  cpu_top dut_i (
    .clk      (clk),
    .reset    (reset),
    .inst     (inst),
    .mem_rdata(mem_rdata),
    .pc       (pc),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_ren  (mem_ren),
    .mem_wen  (mem_wen),
    .hlt      (hlt)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // Fill patterns, then program and data from the stimulus file
  task automatic load_stimulus();
    logic [3:0] tag;
    word_t      addr;
    word_t      data;
    for (int i = 0; i < 256; i++) begin
      stim[i] = '0;
      imem[i] = {4'hF, 12'(i)};
    end
    for (int i = 0; i < 1024; i++) begin
      dmem[i] = 16'(i * 2) ^ 16'hC3C3;
    end
    $readmemh(STIM_FILE, stim);
    prog_words = 0;
    halt_pc = '0;
    for (int i = 0; i < 256; i++) begin
      tag  = stim[i][35:32];
      addr = stim[i][31:16];
      data = stim[i][15:0];
      case (tag)
        4'h1: begin
          imem[addr[8:1]] = data;
          prog_words++;
        end
        4'h2: dmem[addr[10:1]] = data;
        4'h3: begin
          exp_addr.push_back(addr);
          exp_data.push_back(data);
        end
        4'h4: halt_pc = addr;
        default: ;
      endcase
    end
    if (prog_words == 0) begin
      report_failure("No program words found in the stimulus file");
    end
  endtask

  // Instruction and load data driven after the edge
  always @(posedge clk) begin
    #(DRIVE_DELAY);
    inst = imem[pc[8:1]];
    if (mem_ren) begin
      mem_rdata = dmem[mem_addr[10:1]];
    end else begin
      mem_rdata = '0;
    end
  end

  // Mid-cycle sampling of stores and reset state
  always @(negedge clk) begin
    if (reset) begin
      check_value("reset_pc", 16'h0000, pc);
      check_value("reset_mem_wen", 16'h0000, {15'b0, mem_wen});
      check_value("reset_hlt", 16'h0000, {15'b0, hlt});
    end else if (mem_wen) begin
      if (store_idx >= exp_addr.size()) begin
        report_failure($sformatf("Store to %h with data %h after the last expected store",
                                 mem_addr, mem_wdata));
      end else begin
        check_value($sformatf("store%0d_addr", store_idx), exp_addr[store_idx], mem_addr);
        check_value($sformatf("store%0d_data", store_idx), exp_data[store_idx], mem_wdata);
        dmem[mem_addr[10:1]] = mem_wdata;
        store_idx++;
      end
    end
  end

  // Watchdog sized from the program length
  initial begin
    longint limit_ns;
    #1;
    limit_ns = longint'(prog_words * 100 + 200 + RESET_CYCLES) * CLK_PERIOD;
    #(limit_ns);
    report_failure("Timeout, hlt never rose");
  end

  initial begin
    reset = 1'b1;
    mem_rdata = '0;
    inst = 16'hF000;
    store_idx = 0;
    load_stimulus();
    inst = imem[0];
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    reset = 1'b0;
    wait (hlt === 1'b1);
    // A few more cycles to catch any late store
    repeat (5) @(negedge clk);
    check_value("halt_pc", halt_pc, pc);
    if (store_idx != exp_addr.size()) begin
      report_failure($sformatf("Only %0d of %0d expected stores seen at halt",
                               store_idx, exp_addr.size()));
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- testbench/cpu_assert.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_assert import cpu_pkg::*; (
  input logic  clk,
  input logic  reset,
  input word_t pc,
  input logic  mem_ren,
  input logic  mem_wen,
  input logic  hlt
);

  // One data memory access per cycle
  a_ren_wen_excl: assert property (@(posedge clk) disable iff (reset) !(mem_ren && mem_wen))
    else $error("mem_ren and mem_wen high together");

  // hlt is a sticky level
  a_hlt_sticky: assert property (@(posedge clk) disable iff (reset) hlt |=> hlt)
    else $error("hlt fell");

  // pc parked after halt
  a_pc_hold: assert property (@(posedge clk) disable iff (reset) hlt |=> $stable(pc))
    else $error("pc moved while halted");

  a_wen_reset: assert property (@(posedge clk) reset |-> !mem_wen)
    else $error("mem_wen high during reset");

endmodule

bind cpu_top cpu_assert assert_i (
  .clk    (clk),
  .reset  (reset),
  .pc     (pc),
  .mem_ren(mem_ren),
  .mem_wen(mem_wen),
  .hlt    (hlt)
);

`default_nettype wire

//--- hw/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t inst,
  input  word_t mem_rdata,
  output word_t pc,
  output word_t mem_addr,
  output word_t mem_wdata,
  output logic  mem_ren,
  output logic  mem_wen,
  output logic  hlt
);

  // IF/ID
  word_t    if_id_inst;
  word_t    if_id_next_pc;
  // Decode
  ctrl_t    ctrl;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  word_t    rs_data;
  word_t    rt_data;
  logic     stall;
  logic     id_flush;
  logic     if_flush;
  logic     branch_taken;
  logic     branch_reg_sel;
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  logic     store_fwd;
  // Execute and later stages
  flags_t   flags;
  ctrl_t    id_ex_ctrl;
  reg_idx_t id_ex_rd;
  reg_idx_t id_ex_rs;
  reg_idx_t id_ex_rt;
  ctrl_t    ex_mem_ctrl;
  reg_idx_t ex_mem_rd;
  reg_idx_t ex_mem_rt;
  word_t    ex_mem_result;
  word_t    ex_mem_store;
  logic     wb_en;
  reg_idx_t wb_idx;
  word_t    wb_data;
  logic     mem_wb_write;

  fetch_unit u_fetch (
    .clk           (clk),
    .reset         (reset),
    .inst          (inst),
    .stall         (stall),
    .if_flush      (if_flush),
    .branch_taken  (branch_taken),
    .branch_reg_sel(branch_reg_sel),
    // BR target comes straight from the register file read
    .branch_reg    (rs_data),
    .pc            (pc),
    .if_id_inst    (if_id_inst),
    .if_id_next_pc (if_id_next_pc)
  );

  pipeline_control u_control (
    .if_id_inst    (if_id_inst),
    .flags         (flags),
    .id_ex_ctrl    (id_ex_ctrl),
    .id_ex_rd      (id_ex_rd),
    .ex_mem_ctrl   (ex_mem_ctrl),
    .ex_mem_rd     (ex_mem_rd),
    .mem_wb_write  (mem_wb_write),
    .mem_wb_rd     (wb_idx),
    .id_ex_rs      (id_ex_rs),
    .id_ex_rt      (id_ex_rt),
    .ex_mem_rt     (ex_mem_rt),
    .ctrl          (ctrl),
    .rs            (rs),
    .rt            (rt),
    .rd            (rd),
    .stall         (stall),
    .id_flush      (id_flush),
    .if_flush      (if_flush),
    .branch_taken  (branch_taken),
    .branch_reg_sel(branch_reg_sel),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b),
    .store_fwd     (store_fwd)
  );

  register_file u_regfile (
    .clk    (clk),
    .reset  (reset),
    .rs     (rs),
    .rt     (rt),
    .wr_idx (wb_idx),
    .wr_en  (wb_en),
    .wr_data(wb_data),
    .rs_data(rs_data),
    .rt_data(rt_data)
  );

  execute_unit u_execute (
    .clk          (clk),
    .reset        (reset),
    .id_flush     (id_flush),
    .ctrl         (ctrl),
    .rs_data      (rs_data),
    .rt_data      (rt_data),
    .inst_low     (if_id_inst[11:0]),
    .next_pc      (if_id_next_pc),
    .rs           (rs),
    .rt           (rt),
    .rd           (rd),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .wb_data      (wb_data),
    .flags        (flags),
    .id_ex_ctrl   (id_ex_ctrl),
    .id_ex_rd     (id_ex_rd),
    .id_ex_rs     (id_ex_rs),
    .id_ex_rt     (id_ex_rt),
    .ex_mem_ctrl  (ex_mem_ctrl),
    .ex_mem_rd    (ex_mem_rd),
    .ex_mem_rt    (ex_mem_rt),
    .ex_mem_result(ex_mem_result),
    .ex_mem_store (ex_mem_store)
  );

  memory_stage u_memory (
    .clk          (clk),
    .reset        (reset),
    .ex_mem_ctrl  (ex_mem_ctrl),
    .ex_mem_rd    (ex_mem_rd),
    .ex_mem_result(ex_mem_result),
    .ex_mem_store (ex_mem_store),
    .store_fwd    (store_fwd),
    .mem_rdata    (mem_rdata),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_ren      (mem_ren),
    .mem_wen      (mem_wen),
    .wb_en        (wb_en),
    .wb_idx       (wb_idx),
    .wb_data      (wb_data),
    .mem_wb_write (mem_wb_write),
    .hlt          (hlt)
  );

endmodule

`default_nettype wire

//--- hw/memory_stage.sv
`timescale 1ns/100ps
`default_nettype none

module memory_stage import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  ctrl_t    ex_mem_ctrl,
  input  reg_idx_t ex_mem_rd,
  input  word_t    ex_mem_result,
  input  word_t    ex_mem_store,
  input  logic     store_fwd,
  input  word_t    mem_rdata,
  output word_t    mem_addr,
  output word_t    mem_wdata,
  output logic     mem_ren,
  output logic     mem_wen,
  output logic     wb_en,
  output reg_idx_t wb_idx,
  output word_t    wb_data,
  output logic     mem_wb_write,
  output logic     hlt
);

  mem_wb_t mem_wb;

  // Data memory ports
  assign mem_addr  = ex_mem_result;
  // Load one ahead supplies the store data
  assign mem_wdata = store_fwd ? wb_data : ex_mem_store;
  assign mem_ren   = ex_mem_ctrl.mem_read;
  assign mem_wen   = ex_mem_ctrl.mem_write;

  // MEM/WB register
  // hlt is sticky once HLT enters MEM/WB
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb.reg_write  <= 1'b0;
      mem_wb.mem_to_reg <= 1'b0;
      hlt               <= 1'b0;
    end else begin
      mem_wb.reg_write  <= ex_mem_ctrl.reg_write;
      mem_wb.mem_to_reg <= ex_mem_ctrl.mem_to_reg;
      if (ex_mem_ctrl.halt) begin
        hlt <= 1'b1;
      end
    end
    mem_wb.rd     <= ex_mem_rd;
    mem_wb.result <= ex_mem_result;
    mem_wb.rdata  <= mem_rdata;
  end

  // Writeback select
  assign wb_en        = mem_wb.reg_write;
  assign mem_wb_write = mem_wb.reg_write;
  assign wb_idx       = mem_wb.rd;
  assign wb_data      = mem_wb.mem_to_reg ? mem_wb.rdata : mem_wb.result;

endmodule

`default_nettype wire

//--- hw/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit import cpu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        id_flush,
  input  ctrl_t       ctrl,
  input  word_t       rs_data,
  input  word_t       rt_data,
  input  logic [11:0] inst_low,
  input  word_t       next_pc,
  input  reg_idx_t    rs,
  input  reg_idx_t    rt,
  input  reg_idx_t    rd,
  input  fwd_sel_t    fwd_a,
  input  fwd_sel_t    fwd_b,
  input  word_t       wb_data,
  output flags_t      flags,
  output ctrl_t       id_ex_ctrl,
  output reg_idx_t    id_ex_rd,
  output reg_idx_t    id_ex_rs,
  output reg_idx_t    id_ex_rt,
  output ctrl_t       ex_mem_ctrl,
  output reg_idx_t    ex_mem_rd,
  output reg_idx_t    ex_mem_rt,
  output word_t       ex_mem_result,
  output word_t       ex_mem_store
);

  id_ex_t id_ex;
  word_t  op_a;
  word_t  op_b;
  word_t  alu_a;
  word_t  alu_b;
  word_t  mem_imm;
  word_t  byte_merge;
  word_t  alu_result;
  word_t  ex_result;
  flags_t alu_flags;
  logic   is_mem;

  // ID/EX register
  // Bubble on flush clears only the controls
  always_ff @(posedge clk) begin
    if (reset || id_flush) begin
      id_ex.ctrl <= '0;
    end else begin
      id_ex.ctrl <= ctrl;
    end
    id_ex.rs_data  <= rs_data;
    id_ex.rt_data  <= rt_data;
    id_ex.inst_low <= inst_low;
    id_ex.next_pc  <= next_pc;
    id_ex.rs       <= rs;
    id_ex.rt       <= rt;
    id_ex.rd       <= rd;
  end

  assign id_ex_ctrl = id_ex.ctrl;
  assign id_ex_rd   = id_ex.rd;
  assign id_ex_rs   = id_ex.rs;
  assign id_ex_rt   = id_ex.rt;

  function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t ex_val,
                                    word_t wb_val);
    word_t val;
    case (sel)
      FWD_EXMEM: val = ex_val;
      FWD_WB:    val = wb_val;
      default:   val = reg_val;
    endcase
    return val;
  endfunction

  assign op_a = fwd_mux(fwd_a, id_ex.rs_data, ex_mem_result, wb_data);
  assign op_b = fwd_mux(fwd_b, id_ex.rt_data, ex_mem_result, wb_data);

  // LW/SW offset is signed and word aligned
  assign is_mem  = id_ex.ctrl.mem_read || id_ex.ctrl.mem_write;
  assign mem_imm = {{11{id_ex.inst_low[3]}}, id_ex.inst_low[3:0], 1'b0};
  // Base address low bit forced to zero
  assign alu_a   = is_mem ? {op_a[15:1], 1'b0} : op_a;
  assign alu_b   = is_mem ? mem_imm : op_b;

  alu u_alu (
    .opcode(id_ex.ctrl.op),
    .a     (alu_a),
    .b     (alu_b),
    .shamt (id_ex.inst_low[3:0]),
    .result(alu_result),
    .flags (alu_flags)
  );

  // LHB has opcode bit 0 set
  assign byte_merge = id_ex.ctrl.op[0] ? {id_ex.inst_low[7:0], op_b[7:0]} :
                                          {op_b[15:8], id_ex.inst_low[7:0]};

  assign ex_result = id_ex.ctrl.is_pcs     ? id_ex.next_pc :
                     id_ex.ctrl.is_lhb_llb ? byte_merge    : alu_result;

  // Flag register
  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else begin
      if (id_ex.ctrl.flag_z_wen) begin
        flags.z <= alu_flags.z;
      end
      if (id_ex.ctrl.flag_vn_wen) begin
        flags.v <= alu_flags.v;
        flags.n <= alu_flags.n;
      end
    end
  end

  // EX/MEM register
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem_ctrl <= '0;
    end else begin
      ex_mem_ctrl <= id_ex.ctrl;
    end
    ex_mem_rd     <= id_ex.rd;
    ex_mem_rt     <= id_ex.rt;
    ex_mem_result <= ex_result;
    // SW data already forwarded here
    ex_mem_store  <= op_b;
  end

endmodule

`default_nettype wire

//--- hw/pipeline_control.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defs.svh"

module pipeline_control import cpu_pkg::*; (
  input  word_t    if_id_inst,
  input  flags_t   flags,
  input  ctrl_t    id_ex_ctrl,
  input  reg_idx_t id_ex_rd,
  input  ctrl_t    ex_mem_ctrl,
  input  reg_idx_t ex_mem_rd,
  input  logic     mem_wb_write,
  input  reg_idx_t mem_wb_rd,
  input  reg_idx_t id_ex_rs,
  input  reg_idx_t id_ex_rt,
  input  reg_idx_t ex_mem_rt,
  output ctrl_t    ctrl,
  output reg_idx_t rs,
  output reg_idx_t rt,
  output reg_idx_t rd,
  output logic     stall,
  output logic     id_flush,
  output logic     if_flush,
  output logic     branch_taken,
  output logic     branch_reg_sel,
  output fwd_sel_t fwd_a,
  output fwd_sel_t fwd_b,
  output logic     store_fwd
);

  opcode_t    op;
  logic [2:0] cond;
  logic       is_alu;
  logic       is_b;
  logic       is_br;
  logic       uses_rs;
  logic       uses_rt;
  logic       writes_rd;
  logic       cond_true;
  logic       load_use;
  logic       flag_stall;
  logic       br_stall;

  // Instruction fields
  assign op   = if_id_inst[15:12];
  assign cond = if_id_inst[11:9];
  assign rd   = if_id_inst[11:8];
  assign rs   = if_id_inst[7:4];
  // SW data and the LLB/LHB merge value live in the rd field
  assign rt = (op == `OP_SW || op == `OP_LLB || op == `OP_LHB) ?
              if_id_inst[11:8] : if_id_inst[3:0];

  // Opcode classes
  assign is_alu = op inside {`OP_ADD, `OP_SUB, `OP_XOR, `OP_SLL, `OP_SRA, `OP_ROR};
  assign is_b   = (op == `OP_B);
  assign is_br  = (op == `OP_BR);
  // Shifts take an immediate in the rt field
  assign uses_rs   = is_alu || op == `OP_LW || op == `OP_SW;
  assign uses_rt   = op inside {`OP_ADD, `OP_SUB, `OP_XOR, `OP_LLB, `OP_LHB};
  assign writes_rd = is_alu || op inside {`OP_LW, `OP_LLB, `OP_LHB, `OP_PCS};

  // Decoded controls
  always_comb begin
    ctrl.op          = op;
    // No write enable ever reaches r0
    // so later stages never forward it
    ctrl.reg_write   = writes_rd && (rd != '0);
    ctrl.mem_read    = (op == `OP_LW);
    ctrl.mem_write   = (op == `OP_SW);
    ctrl.mem_to_reg  = (op == `OP_LW);
    ctrl.flag_z_wen  = is_alu;
    ctrl.flag_vn_wen = (op == `OP_ADD) || (op == `OP_SUB);
    ctrl.is_pcs      = (op == `OP_PCS);
    ctrl.is_lhb_llb  = (op == `OP_LLB) || (op == `OP_LHB);
    ctrl.halt        = (op == `OP_HLT);
  end

  // Branch condition against the flag register
  always_comb begin
    case (cond)
      `BR_NE:  cond_true = !flags.z;
      `BR_EQ:  cond_true = flags.z;
      `BR_GT:  cond_true = !flags.z && !flags.n;
      `BR_LT:  cond_true = flags.n;
      `BR_GE:  cond_true = flags.z || !flags.n;
      `BR_LE:  cond_true = flags.z || flags.n;
      `BR_OV:  cond_true = flags.v;
      default: cond_true = 1'b1;
    endcase
  end

  // Load result not ready for a consumer directly behind it
  assign load_use = id_ex_ctrl.mem_read && id_ex_ctrl.reg_write &&
                    ((uses_rs && rs == id_ex_rd) || (uses_rt && rt == id_ex_rd));
  // Flags land at the end of EX
  assign flag_stall = (is_b || is_br) && (cond != `BR_UNCOND) &&
                      (id_ex_ctrl.flag_z_wen || id_ex_ctrl.flag_vn_wen);
  // BR target only via the register file bypass
  assign br_stall = is_br && ((id_ex_ctrl.reg_write && id_ex_rd == rs) ||
                              (ex_mem_ctrl.reg_write && ex_mem_rd == rs));

  assign stall    = load_use || flag_stall || br_stall;
  // Held instruction leaves a bubble in EX
  assign id_flush = stall;

  // Branch resolves in ID
  assign branch_taken   = (is_b || is_br) && cond_true && !stall;
  assign branch_reg_sel = is_br;
  // Wrong-path fetch is squashed
  assign if_flush       = branch_taken;

  // Newer EX/MEM result beats MEM/WB
  function automatic fwd_sel_t pick_src(reg_idx_t idx);
    fwd_sel_t sel;
    sel = FWD_REG;
    if (mem_wb_write && mem_wb_rd == idx)
      sel = FWD_WB;
    if (ex_mem_ctrl.reg_write && ex_mem_rd == idx)
      sel = FWD_EXMEM;
    return sel;
  endfunction

  always_comb begin
    fwd_a = pick_src(id_ex_rs);
    fwd_b = pick_src(id_ex_rt);
  end

  // Store data from a load one ahead
  assign store_fwd = ex_mem_ctrl.mem_write && mem_wb_write && (mem_wb_rd == ex_mem_rt);

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defs.svh"

module fetch_unit import cpu_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t inst,
  input  logic  stall,
  input  logic  if_flush,
  input  logic  branch_taken,
  input  logic  branch_reg_sel,
  input  word_t branch_reg,
  output word_t pc,
  output word_t if_id_inst,
  output word_t if_id_next_pc
);

  word_t next_pc;
  word_t branch_offset;
  word_t branch_target;
  word_t pc_in;
  logic  hlt_fetched;
  logic  pc_en;

  assign next_pc = pc + `PC_STEP;

  // Signed word offset scaled to bytes
  assign branch_offset = {{6{if_id_inst[8]}}, if_id_inst[8:0], 1'b0};
  // Relative to the address after the branch
  assign branch_target = branch_reg_sel ? branch_reg : (if_id_next_pc + branch_offset);
  assign pc_in = branch_taken ? branch_target : next_pc;

  // HLT parks pc
  // unless a taken branch in ID squashes it
  assign hlt_fetched = (inst[15:12] == `OP_HLT) && !if_flush;
  assign pc_en = !stall && !hlt_fetched;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (pc_en) begin
      pc <= pc_in;
    end
  end

  // IF/ID register
  // Held on a stall
  always_ff @(posedge clk) begin
    if (reset || if_flush) begin
      if_id_inst <= `CPU_NOP;
    end else if (!stall) begin
      if_id_inst    <= inst;
      if_id_next_pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defs.svh"

module alu import cpu_pkg::*; (
  input  opcode_t    opcode,
  input  word_t      a,
  input  word_t      b,
  input  logic [3:0] shamt,
  output word_t      result,
  output flags_t     flags
);

  logic        sub_op;
  word_t       b_eff;
  word_t       sum;
  word_t       sat_sum;
  logic        ovf_pos;
  logic        ovf_neg;
  logic [31:0] rot_pair;

  // Subtract as a + ~b + 1
  assign sub_op = (opcode == `OP_SUB);
  assign b_eff  = sub_op ? ~b : b;
  assign sum    = a + b_eff + word_t'(sub_op);

  // Two like-signed inputs giving the other sign
  assign ovf_pos = !a[`CPU_WORD_W-1] && !b_eff[`CPU_WORD_W-1] && sum[`CPU_WORD_W-1];
  assign ovf_neg = a[`CPU_WORD_W-1] && b_eff[`CPU_WORD_W-1] && !sum[`CPU_WORD_W-1];

  // Clamp to the signed limits
  assign sat_sum = ovf_pos ? 16'h7FFF : (ovf_neg ? 16'h8000 : sum);

  // Rotate via a doubled word
  assign rot_pair = {a, a} >> shamt;

  always_comb begin
    case (opcode)
      `OP_ADD, `OP_SUB: result = sat_sum;
      // Address add wraps
      `OP_LW, `OP_SW:   result = sum;
      `OP_XOR:          result = a ^ b;
      `OP_SLL:          result = a << shamt;
      `OP_SRA:          result = $signed(a) >>> shamt;
      `OP_ROR:          result = rot_pair[`CPU_WORD_W-1:0];
      default:          result = '0;
    endcase
  end

  // V and N only meaningful for ADD and SUB
  assign flags.z = (result == '0);
  assign flags.v = ovf_pos || ovf_neg;
  assign flags.n = sat_sum[`CPU_WORD_W-1];

endmodule

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_defs.svh"

module register_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs,
  input  reg_idx_t rt,
  input  reg_idx_t wr_idx,
  input  logic     wr_en,
  input  word_t    wr_data,
  output word_t    rs_data,
  output word_t    rt_data
);

  word_t regs [`CPU_REG_CNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // Same-cycle write shows through to decode
  function automatic word_t read_port(reg_idx_t idx);
    word_t val;
    val = regs[idx];
    if (wr_en && wr_idx == idx)
      val = wr_data;
    // r0 reads zero
    if (idx == '0)
      val = '0;
    return val;
  endfunction

  always_comb begin
    rs_data = read_port(rs);
    rt_data = read_port(rt);
  end

endmodule

`default_nettype wire

//--- hw/cpu_pkg.sv
`default_nettype none
`include "cpu_defs.svh"

package cpu_pkg;

  typedef logic [`CPU_WORD_W-1:0] word_t;
  typedef logic [$clog2(`CPU_REG_CNT)-1:0] reg_idx_t;
  typedef logic [3:0] opcode_t;

  // Flag register layout
  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  // Decoded controls carried down the pipe
  typedef struct packed {
    opcode_t op;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    flag_z_wen;
    logic    flag_vn_wen;
    logic    is_pcs;
    logic    is_lhb_llb;
    logic    halt;
  } ctrl_t;

  // Operand source in EX
  typedef enum logic [1:0] {
    FWD_REG   = 2'd0,
    FWD_EXMEM = 2'd1,
    FWD_WB    = 2'd2
  } fwd_sel_t;

  // ID/EX payload
  typedef struct packed {
    ctrl_t       ctrl;
    word_t       rs_data;
    word_t       rt_data;
    logic [11:0] inst_low;
    word_t       next_pc;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
  } id_ex_t;

  // MEM/WB payload
  typedef struct packed {
    logic     reg_write;
    logic     mem_to_reg;
    reg_idx_t rd;
    word_t    result;
    word_t    rdata;
  } mem_wb_t;

endpackage

`default_nettype wire

//--- hw/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath sizing
`define CPU_WORD_W  16
`define CPU_REG_CNT 16

// Fetch increment in bytes
`define PC_STEP 16'd2

// Opcodes in bits 15:12
// 0011 and 0111 are not implemented
`define OP_ADD 4'b0000
`define OP_SUB 4'b0001
`define OP_XOR 4'b0010
`define OP_SLL 4'b0100
`define OP_SRA 4'b0101
`define OP_ROR 4'b0110
`define OP_LW  4'b1000
`define OP_SW  4'b1001
`define OP_LLB 4'b1010
`define OP_LHB 4'b1011
`define OP_B   4'b1100
`define OP_BR  4'b1101
`define OP_PCS 4'b1110
`define OP_HLT 4'b1111

// Bubble word
// LLB r0 has no effect because r0 is never written
`define CPU_NOP 16'hA000

// Branch conditions in bits 11:9
`define BR_NE     3'b000
`define BR_EQ     3'b001
`define BR_GT     3'b010
`define BR_LT     3'b011
`define BR_GE     3'b100
`define BR_LE     3'b101
`define BR_OV     3'b110
`define BR_UNCOND 3'b111

`endif
